//--- source/xbus_cfg.svh
`ifndef XBUS_CFG_SVH
`define XBUS_CFG_SVH

// Xbus word address and data widths
`define XBUS_ADDR_BITS 22
`define XBUS_DATA_BITS 32

// small RAM so the top word is easy to reach
`define XBUS_RAM_BITS 10
`define XBUS_RAM_SIZE (1 << `XBUS_RAM_BITS)

// first address past the memory window
`define XBUS_WINDOW_LIMIT 22'o11000000

// wait cycles in front of every RAM access
`define XBUS_RAM_WAIT 1

`endif

//--- source/xbus_pkg.sv
`include "xbus_cfg.svh"

package xbus_pkg;

   typedef logic [`XBUS_ADDR_BITS-1:0] xbus_addr_t;
   typedef logic [`XBUS_DATA_BITS-1:0] xbus_word_t;

   // request as held in the decode stage
   typedef struct packed {
      xbus_addr_t addr;
      logic       write;
      xbus_word_t data;
      logic       in_window;
   } xbus_req_t;

   // response as held in the return stage
   typedef struct packed {
      logic       write;
      xbus_word_t data;
   } xbus_rsp_t;

endpackage

//--- source/xbus_slice.sv
`timescale 1ns/1ns

module xbus_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_payload,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_payload
);

   logic     full;
   payload_t held;

   // take a new item when empty or when the held one leaves now
   assign in_ready    = !full || out_ready;
   assign out_valid   = full;
   assign out_payload = held;

   always_ff @(posedge clk)
   begin
      if (reset)
         full <= 1'b0;
      else if (in_ready)
         full <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         held <= in_payload;
   end

endmodule

//--- source/xbus_decode.sv
`timescale 1ns/1ns

`include "xbus_cfg.svh"

module xbus_decode (
   input  logic                clk,
   input  logic                reset,
   input  logic                req_valid,
   output logic                req_ready,
   input  xbus_pkg::xbus_addr_t req_addr,
   input  logic                req_write,
   input  xbus_pkg::xbus_word_t req_data,
   output logic                dec_valid,
   input  logic                dec_ready,
   output xbus_pkg::xbus_addr_t dec_addr,
   output logic                dec_write,
   output xbus_pkg::xbus_word_t dec_data,
   output logic                dec_in_window
);

   xbus_pkg::xbus_req_t req_in;
   xbus_pkg::xbus_req_t req_out;

   // memory window covers everything below the limit
   assign req_in.addr      = req_addr;
   assign req_in.write     = req_write;
   assign req_in.data      = req_data;
   assign req_in.in_window = (req_addr < `XBUS_WINDOW_LIMIT);

   xbus_slice #(
      .payload_t (xbus_pkg::xbus_req_t)
   ) req_slice (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (req_valid),
      .in_ready    (req_ready),
      .in_payload  (req_in),
      .out_valid   (dec_valid),
      .out_ready   (dec_ready),
      .out_payload (req_out)
   );

   assign dec_addr      = req_out.addr;
   assign dec_write     = req_out.write;
   assign dec_data      = req_out.data;
   assign dec_in_window = req_out.in_window;

endmodule

//--- source/xbus_ram.sv
`timescale 1ns/1ns

`include "xbus_cfg.svh"

module xbus_ram (
   input  logic                clk,
   input  logic                reset,
   input  logic                dec_valid,
   output logic                dec_ready,
   input  xbus_pkg::xbus_addr_t dec_addr,
   input  logic                dec_write,
   input  xbus_pkg::xbus_word_t dec_data,
   input  logic                dec_in_window,
   output logic                mem_valid,
   input  logic                mem_ready,
   output logic                mem_write,
   output xbus_pkg::xbus_word_t mem_data,
   output logic                mem_backed
);

   localparam int cnt_bits = (`XBUS_RAM_WAIT > 0) ? $clog2(`XBUS_RAM_WAIT + 1) : 1;

   xbus_pkg::xbus_word_t ram [0:`XBUS_RAM_SIZE-1];

   // captured request
   xbus_pkg::xbus_addr_t cur_addr;
   logic                 cur_write;
   xbus_pkg::xbus_word_t cur_data;
   logic                 cur_in_window;

   logic                 busy;
   logic [cnt_bits-1:0]  wait_cnt;
   logic                 take;
   logic                 access;
   logic                 backed;
   logic [`XBUS_RAM_BITS-1:0] index;

   initial
   begin
      for (int i = 0; i < `XBUS_RAM_SIZE; i++)
         ram[i] = '0;
   end

   // one request at a time, and only once the last result has left
   assign dec_ready = !busy && (!mem_valid || mem_ready);
   assign take      = dec_valid && dec_ready;
   assign access    = busy && (wait_cnt == '0);

   // only the low part of the window has storage behind it
   assign backed = cur_in_window && (cur_addr < `XBUS_RAM_SIZE);
   assign index  = cur_addr[`XBUS_RAM_BITS-1:0];

   always_ff @(posedge clk)
   begin
      if (take)
      begin
         cur_addr      <= dec_addr;
         cur_write     <= dec_write;
         cur_data      <= dec_data;
         cur_in_window <= dec_in_window;
      end
   end

   // wait counter and result handshake
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         wait_cnt  <= '0;
         mem_valid <= 1'b0;
      end
      else
      begin
         if (mem_valid && mem_ready)
            mem_valid <= 1'b0;
         if (take)
         begin
            busy     <= 1'b1;
            wait_cnt <= cnt_bits'(`XBUS_RAM_WAIT);
         end
         else if (access)
         begin
            busy      <= 1'b0;
            mem_valid <= 1'b1;
         end
         else if (busy)
            wait_cnt <= wait_cnt - 1'b1;
      end
   end

   // array access once the wait has run out
   always_ff @(posedge clk)
   begin
      if (access)
      begin
         if (cur_write && backed)
            ram[index] <= cur_data;
         mem_data   <= ram[index];
         mem_write  <= cur_write;
         mem_backed <= backed;
      end
   end

endmodule

//--- source/xbus_return.sv
`timescale 1ns/1ns

module xbus_return (
   input  logic                clk,
   input  logic                reset,
   input  logic                mem_valid,
   output logic                mem_ready,
   input  logic                mem_write,
   input  xbus_pkg::xbus_word_t mem_data,
   input  logic                mem_backed,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output logic                rsp_write,
   output xbus_pkg::xbus_word_t rsp_data
);

   xbus_pkg::xbus_rsp_t rsp_in;
   xbus_pkg::xbus_rsp_t rsp_out;

   assign rsp_in.write = mem_write;

   // writes carry no data, unbacked reads float high
   always_comb
   begin
      if (mem_write)
         rsp_in.data = '0;
      else if (mem_backed)
         rsp_in.data = mem_data;
      else
         rsp_in.data = '1;
   end

   xbus_slice #(
      .payload_t (xbus_pkg::xbus_rsp_t)
   ) rsp_slice (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (mem_valid),
      .in_ready    (mem_ready),
      .in_payload  (rsp_in),
      .out_valid   (rsp_valid),
      .out_ready   (rsp_ready),
      .out_payload (rsp_out)
   );

   assign rsp_write = rsp_out.write;
   assign rsp_data  = rsp_out.data;

endmodule

//--- source/xbus_mem_top.sv
`timescale 1ns/1ns

module xbus_mem_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                req_valid,
   output logic                req_ready,
   input  xbus_pkg::xbus_addr_t req_addr,
   input  logic                req_write,
   input  xbus_pkg::xbus_word_t req_data,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output logic                rsp_write,
   output xbus_pkg::xbus_word_t rsp_data
);

   // decode to RAM
   logic                 dec_valid;
   logic                 dec_ready;
   xbus_pkg::xbus_addr_t dec_addr;
   logic                 dec_write;
   xbus_pkg::xbus_word_t dec_data;
   logic                 dec_in_window;

   // RAM to return
   logic                 mem_valid;
   logic                 mem_ready;
   logic                 mem_write;
   xbus_pkg::xbus_word_t mem_data;
   logic                 mem_backed;

   xbus_decode decode (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req_addr      (req_addr),
      .req_write     (req_write),
      .req_data      (req_data),
      .dec_valid     (dec_valid),
      .dec_ready     (dec_ready),
      .dec_addr      (dec_addr),
      .dec_write     (dec_write),
      .dec_data      (dec_data),
      .dec_in_window (dec_in_window)
   );

   xbus_ram ram (
      .clk           (clk),
      .reset         (reset),
      .dec_valid     (dec_valid),
      .dec_ready     (dec_ready),
      .dec_addr      (dec_addr),
      .dec_write     (dec_write),
      .dec_data      (dec_data),
      .dec_in_window (dec_in_window),
      .mem_valid     (mem_valid),
      .mem_ready     (mem_ready),
      .mem_write     (mem_write),
      .mem_data      (mem_data),
      .mem_backed    (mem_backed)
   );

   xbus_return ret (
      .clk        (clk),
      .reset      (reset),
      .mem_valid  (mem_valid),
      .mem_ready  (mem_ready),
      .mem_write  (mem_write),
      .mem_data   (mem_data),
      .mem_backed (mem_backed),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_write  (rsp_write),
      .rsp_data   (rsp_data)
   );

endmodule

//--- verification/xbus_sva.sv
`timescale 1ns/1ns

module xbus_sva (
   input logic                 clk,
   input logic                 reset,
   input logic                 req_valid,
   input logic                 req_ready,
   input logic                 rsp_valid,
   input logic                 rsp_ready,
   input logic                 rsp_write,
   input xbus_pkg::xbus_word_t rsp_data
);

   // requests taken but not yet answered
   logic [7:0] in_flight;

   always_ff @(posedge clk)
   begin
      if (reset)
         in_flight <= '0;
      else
         in_flight <= in_flight + 8'(req_valid && req_ready) - 8'(rsp_valid && rsp_ready);
   end

   held_rsp: assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_write) && $stable(rsp_data))
      else $error("response dropped or changed while stalled");

   reset_idle: assert property (@(posedge clk) reset |=> !rsp_valid && req_ready)
      else $error("channels not idle after reset");

   no_orphan: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> in_flight != 0)
      else $error("response without an outstanding request");

   // decode, RAM and return hold one each
   max_depth: assert property (@(posedge clk) disable iff (reset)
      in_flight <= 8'd3)
      else $error("more than three requests in flight");

endmodule

//--- verification/xbus_tb.sv
`timescale 1ns/1ns

`include "xbus_cfg.svh"

module xbus_tb;

   localparam int max_ops = 64;

   logic                 clk;
   logic                 reset;
   logic                 req_valid;
   logic                 req_ready;
   xbus_pkg::xbus_addr_t req_addr;
   logic                 req_write;
   xbus_pkg::xbus_word_t req_data;
   logic                 rsp_valid;
   logic                 rsp_ready;
   logic                 rsp_write;
   xbus_pkg::xbus_word_t rsp_data;

   // four words per operation: kind, address, write data, expected data
   logic [31:0] pat [0:4*max_ops-1];

   // expected responses in request order
   logic                 exp_write [$];
   xbus_pkg::xbus_word_t exp_data [$];

   int     n_ops;
   int     rsp_count;
   int     cycle_count = 0;
   int     cycle_limit;
   integer seed;

   xbus_mem_top dut (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_write (req_write),
      .req_data  (req_data),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_write (rsp_write),
      .rsp_data  (rsp_data)
   );

   bind xbus_mem_top xbus_sva sva (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_write (rsp_write),
      .rsp_data  (rsp_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
         abort_run($sformatf("timeout: no end of run within %0d cycles", cycle_limit));
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want)
         abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, want));
   endtask

   task automatic load_patterns();
      // fill so that unused slots never look like a valid kind
      for (int i = 0; i < 4*max_ops; i++)
         pat[i] = ~i;
      $readmemh("verification/xbus_patterns.txt", pat);
      n_ops = 0;
      while (n_ops < max_ops && pat[4*n_ops] < 2)
      begin
         exp_write.push_back(pat[4*n_ops][0]);
         exp_data.push_back(pat[4*n_ops+3]);
         n_ops++;
      end
      if (n_ops == 0)
         abort_run("no operations found in the pattern file");
      cycle_limit = 40 * n_ops + 100;
   endtask

   task automatic send_request(input logic [31:0] kind, input logic [31:0] addr,
                               input logic [31:0] data);
      req_valid = 1'b1;
      req_write = kind[0];
      req_addr  = addr[`XBUS_ADDR_BITS-1:0];
      req_data  = data;
      // ready seen high mid-cycle means transfer at the next edge
      @(negedge clk);
      while (!req_ready)
         @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic drive_requests();
      for (int i = 0; i < n_ops; i++)
         send_request(pat[4*i], pat[4*i+1], pat[4*i+2]);
      req_valid = 1'b0;
   endtask

   task automatic collect_responses();
      logic                 want_write;
      xbus_pkg::xbus_word_t want_data;
      while (rsp_count < n_ops)
      begin
         @(posedge clk);
         #1;
         // stall the response side about three cycles in eight
         rsp_ready = (($random(seed) & 7) > 2);
         @(negedge clk);
         if (rsp_valid && rsp_ready)
         begin
            want_write = exp_write.pop_front();
            want_data  = exp_data.pop_front();
            check_value("rsp_write", {31'b0, rsp_write}, {31'b0, want_write});
            check_value("rsp_data", rsp_data, want_data);
            rsp_count++;
         end
      end
   endtask

   initial
   begin
      seed        = 32'hf07;
      reset       = 1'b1;
      req_valid   = 1'b0;
      req_addr    = '0;
      req_write   = 1'b0;
      req_data    = '0;
      rsp_ready   = 1'b0;
      rsp_count   = 0;
      cycle_limit = 0;
      load_patterns();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      fork
         drive_requests();
         collect_responses();
      join
      // nothing more may come out once every request is answered
      @(posedge clk);
      #1;
      rsp_ready = 1'b1;
      repeat (5)
      begin
         @(negedge clk);
         if (rsp_valid)
            abort_run("extra response after the last expected one");
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- verification/xbus_patterns.txt
// kind (0 read, 1 write), word address, write data, expected rsp_data
// writes answer with zero, unbacked and unmapped reads with all ones
// fresh RAM reads as zero
0 000005 00000000 00000000
0 0003fe 00000000 00000000
// storage at the bottom and top words
1 000000 11111111 00000000
0 000000 00000000 11111111
1 0003ff a5a5a5a5 00000000
0 0003ff 00000000 a5a5a5a5
// window words past the RAM
1 000400 deadbeef 00000000
0 000400 00000000 ffffffff
0 000000 00000000 11111111
1 23ffff 0badf00d 00000000
0 23ffff 00000000 ffffffff
0 0003ff 00000000 a5a5a5a5
// outside the window
1 240000 cafef00d 00000000
0 240000 00000000 ffffffff
1 3ffc00 12345678 00000000
0 3ffc00 00000000 ffffffff
0 3fffff 00000000 ffffffff
0 000000 00000000 11111111
// back to back burst
1 000010 00000010 00000000
1 000011 20000011 00000000
1 000012 30000012 00000000
1 000013 40000013 00000000
0 000010 00000000 00000010
0 000011 00000000 20000011
1 000010 5555aaaa 00000000
0 000010 00000000 5555aaaa
0 000012 00000000 30000012
0 000013 00000000 40000013
1 000200 87654321 00000000
0 000200 00000000 87654321
0 000201 00000000 00000000
0 000011 00000000 20000011
0 240001 00000000 ffffffff
1 000201 fedcba98 00000000
0 000201 00000000 fedcba98
0 000200 00000000 87654321

//--- build.f
+incdir+source
source/xbus_pkg.sv
source/xbus_slice.sv
source/xbus_decode.sv
source/xbus_ram.sv
source/xbus_return.sv
source/xbus_mem_top.sv
verification/xbus_sva.sv
verification/xbus_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module xbus_tb -f build.f -o xbus_sim

# the simulation may stop through $fatal, so its status is judged from the log
./obj_dir/xbus_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
   exit 0
fi
exit 1
